//--- all.f
hw/cluster_periph_pkg.sv
hw/periph_reg_pkg.sv
hw/periph_reg_file.sv
hw/perf_counter_bank.sv
hw/cluster_peripheral.sv
test/cluster_peripheral_checker.sv
test/tb_cluster_peripheral.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the cluster peripheral testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_cluster_peripheral -f all.f -o sim_tb

output=$(./obj_dir/sim_tb 2>&1 || true)
echo "$output"

if grep -qx "Simulation completed successfully" <<< "$output"; then
  exit 0
else
  exit 1
fi

//--- test/tb_cluster_peripheral.sv
// Testbench for the cluster peripheral. Applies a table of register accesses
// under random event traffic and checks each response against a reference model.

`timescale 1ns/1ps

module tb_cluster_peripheral;

  import cluster_periph_pkg::*;
  import periph_reg_pkg::*;

  localparam int unsigned ClkPeriod = 8;
  localparam int unsigned ResetCycles = 8;
  localparam logic [1:0] KindNone = 2'd0;
  localparam logic [1:0] KindFixed = 2'd1;
  localparam logic [1:0] KindModel = 2'd2;
  localparam logic [1:0] KindIdle = 2'd3;

  // One bus access, or for KindIdle a run of wdata cycles without access.
  typedef struct packed {
    logic        write;
    logic [7:0]  addr;
    logic [31:0] wdata;
    logic [1:0]  kind;
    logic [31:0] expected;
    logic        error;
  } access_t;

  logic                                clk_i;
  logic                                reset_i;
  reg_req_t                            reg_req_i;
  reg_rsp_t                            reg_rsp_o;
  logic [HartIdWidth-1:0]              hart_base_id_i;
  core_events_t [NrCores-1:0]          core_events_i;
  tcdm_events_t                        tcdm_events_i;
  dma_events_t                         dma_events_i;
  icache_events_t [NrCores-1:0]        icache_events_i;
  logic [NrCores-1:0]                  cl_clint_o;
  logic                                icache_prefetch_enable_o;

  access_t table_q[$];
  integer  seed;

  // Reference model state, including its own copy of the event register stage.
  counter_t                     cnt_m [NumPerfCounters];
  logic [3:0]                   metric_m [NumPerfCounters];
  hart_sel_t                    hsel_m [NumPerfCounters];
  logic [NrCores-1:0]           clint_m;
  logic                         prefetch_m;
  core_events_t [NrCores-1:0]   core_m;
  tcdm_events_t                 tcdm_m;
  dma_events_t                  dma_m;
  icache_events_t [NrCores-1:0] icache_m;

  cluster_peripheral cluster_peripheral_inst (.*);

  bind cluster_peripheral cluster_peripheral_checker cluster_peripheral_checker_inst (
    .clk_i(clk_i), .reset_i(reset_i), .reg_req_i(reg_req_i), .reg_rsp_i(reg_rsp_o),
    .cl_clint_i(cl_clint_o)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #(ClkPeriod / 2) clk_i = ~clk_i;
    end
  end

  function automatic void add_access(logic write, logic [7:0] addr, logic [31:0] wdata,
                                     logic [1:0] kind, logic [31:0] expected, logic error);
    table_q.push_back({write, addr, wdata, kind, expected, error});
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Mismatch at time %0t: %s got 0x%0h expected 0x%0h",
               $time, name, actual, expected);
      $display("Simulation failed");
      $fatal(1, "Stopping at first mismatch");
    end
  endtask

  // Increment per metric code from the registered events.
  function automatic counter_t metric_inc(logic [3:0] metric, hart_sel_t hart);
    case (metric)
      4'd0: return counter_t'(1);
      4'd1: return counter_t'(tcdm_m.accessed);
      4'd2: return counter_t'(tcdm_m.congested);
      4'd3: return counter_t'(core_m[hart].retired_instr);
      4'd4: return counter_t'(core_m[hart].retired_load);
      4'd5: return counter_t'(dma_m.busy);
      4'd6: return counter_t'(dma_m.bytes_written);
      4'd7: return counter_t'(icache_m[hart].miss);
      4'd8: return counter_t'(icache_m[hart].hit);
      default: return '0;
    endcase
  endfunction

  // Advances the model by one clock edge.
  task automatic update_model(input logic valid, input access_t a);
    logic wr;
    wr = valid & a.write;
    for (int i = 0; i < NumPerfCounters; i++) begin
      if (wr && a.addr == 8'h20 + 8'(8 * i)) begin
        cnt_m[i] = counter_t'(a.wdata);
      end else begin
        cnt_m[i] = cnt_m[i] + metric_inc(metric_m[i], hsel_m[i]);
      end
      if (wr && a.addr == 8'h40 + 8'(4 * i)) begin
        metric_m[i] = a.wdata[3:0];
      end
      if (wr && a.addr == 8'h50 + 8'(4 * i)) begin
        hsel_m[i] = a.wdata[HartSelWidth-1:0];
      end
    end
    if (wr && a.addr == 8'h00) begin
      prefetch_m = a.wdata[0];
    end
    if (wr && a.addr == 8'h04) begin
      clint_m = clint_m | a.wdata[NrCores-1:0];
    end
    if (wr && a.addr == 8'h08) begin
      clint_m = clint_m & ~a.wdata[NrCores-1:0];
    end
    core_m = core_events_i;
    tcdm_m = tcdm_events_i;
    dma_m = dma_events_i;
    icache_m = icache_events_i;
  endtask

  // Drives one table entry from the falling edge and checks mid-cycle.
  task automatic run_access(input access_t a);
    int unsigned cycles;
    int unsigned idx;
    logic        valid;
    logic [31:0] rnd;
    logic [31:0] expected;
    cycles = (a.kind == KindIdle) ? a.wdata : 1;
    valid = (a.kind != KindIdle);
    for (int unsigned n = 0; n < cycles; n++) begin
      reg_req_i = {valid, valid & a.write, a.addr, a.wdata};
      rnd = $random(seed);
      core_events_i = rnd[7:0];
      tcdm_events_i = rnd[9:8];
      dma_events_i = rnd[18:10];
      icache_events_i = rnd[26:19];
      #(ClkPeriod / 4);
      check_value("cl_clint_o", 32'(cl_clint_o), 32'(clint_m));
      check_value("icache_prefetch_enable_o", 32'(icache_prefetch_enable_o), 32'(prefetch_m));
      if (valid) begin
        check_value("reg_rsp_o.error", 32'(reg_rsp_o.error), 32'(a.error));
      end
      if (valid && !a.write && a.kind == KindFixed) begin
        check_value("reg_rsp_o.rdata", reg_rsp_o.rdata, a.expected);
      end
      if (valid && !a.write && a.kind == KindModel) begin
        idx = int'(a.addr - 8'h20) >> 3;
        expected = a.addr[2] ? 32'(cnt_m[idx][47:32]) : cnt_m[idx][31:0];
        check_value("reg_rsp_o.rdata", reg_rsp_o.rdata, expected);
      end
      update_model(valid, a);
      @(negedge clk_i);
    end
  endtask

  function automatic void build_table();
    // Reset values.
    add_access(0, 8'h00, 0, KindFixed, 32'h1, 0);
    add_access(0, 8'h0C, 0, KindFixed, 32'h0, 0);
    add_access(0, 8'h10, 0, KindFixed, 32'h2A5, 0);
    add_access(0, 8'h40, 0, KindFixed, 32'h0, 0);
    add_access(0, 8'h44, 0, KindFixed, 32'h3, 0);
    add_access(0, 8'h48, 0, KindFixed, 32'h1, 0);
    add_access(0, 8'h4C, 0, KindFixed, 32'h7, 0);
    // Wake-up bits.
    add_access(1, 8'h04, 32'h5, KindNone, 0, 0);
    add_access(1, 8'h04, 32'h2, KindNone, 0, 0);
    add_access(0, 8'h0C, 0, KindFixed, 32'h7, 0);
    add_access(1, 8'h08, 32'h4, KindNone, 0, 0);
    add_access(0, 8'h0C, 0, KindFixed, 32'h3, 0);
    add_access(0, 8'h04, 0, KindFixed, 32'h0, 0);
    add_access(0, 8'h08, 0, KindFixed, 32'h0, 0);
    // Prefetch enable.
    add_access(1, 8'h00, 32'h0, KindNone, 0, 0);
    add_access(0, 8'h00, 0, KindFixed, 32'h0, 0);
    add_access(1, 8'h00, 32'h1, KindNone, 0, 0);
    // Load then five more cycles of Cycle counting.
    add_access(1, 8'h20, 32'h1000, KindNone, 0, 0);
    add_access(0, 8'h00, 32'd5, KindIdle, 0, 0);
    add_access(0, 8'h20, 0, KindFixed, 32'h1005, 0);
    // Byte sums near the 32-bit boundary, per-hart metrics and an unused code.
    add_access(1, 8'h40, 32'h6, KindNone, 0, 0);
    add_access(1, 8'h20, 32'hFFFF_FF00, KindNone, 0, 0);
    add_access(1, 8'h44, 32'h4, KindNone, 0, 0);
    add_access(1, 8'h54, 32'h2, KindNone, 0, 0);
    add_access(1, 8'h4C, 32'h8, KindNone, 0, 0);
    add_access(1, 8'h5C, 32'h3, KindNone, 0, 0);
    add_access(1, 8'h48, 32'hF, KindNone, 0, 0);
    add_access(0, 8'h00, 32'd80, KindIdle, 0, 0);
    add_access(0, 8'h20, 0, KindModel, 0, 0);
    add_access(0, 8'h24, 0, KindModel, 0, 0);
    add_access(0, 8'h28, 0, KindModel, 0, 0);
    add_access(0, 8'h30, 0, KindModel, 0, 0);
    add_access(0, 8'h38, 0, KindModel, 0, 0);
    // Interconnect congestion and DMA busy.
    add_access(1, 8'h44, 32'h2, KindNone, 0, 0);
    add_access(1, 8'h48, 32'h5, KindNone, 0, 0);
    add_access(0, 8'h00, 32'd20, KindIdle, 0, 0);
    add_access(0, 8'h28, 0, KindModel, 0, 0);
    add_access(0, 8'h30, 0, KindModel, 0, 0);
    // Errors leave the state alone.
    add_access(0, 8'h14, 0, KindNone, 0, 1);
    add_access(0, 8'h01, 0, KindNone, 0, 1);
    add_access(1, 8'h0C, 32'hF, KindNone, 0, 1);
    add_access(1, 8'h24, 32'hFFFF, KindNone, 0, 1);
    add_access(0, 8'h24, 0, KindModel, 0, 0);
    add_access(0, 8'h0C, 0, KindFixed, 32'h3, 0);
  endfunction

  initial begin
    int unsigned wait_cycles;
    seed = 71983;
    reset_i = 1'b1;
    reg_req_i = '0;
    hart_base_id_i = 10'h2A5;
    core_events_i = '0;
    tcdm_events_i = '0;
    dma_events_i = '0;
    icache_events_i = '0;
    for (int i = 0; i < NumPerfCounters; i++) begin
      cnt_m[i] = '0;
      hsel_m[i] = '0;
    end
    metric_m = '{4'd0, 4'd3, 4'd1, 4'd7};
    clint_m = '0;
    prefetch_m = 1'b1;
    core_m = '0;
    tcdm_m = '0;
    dma_m = '0;
    icache_m = '0;
    build_table();
    wait_cycles = 0;
    while (cl_clint_o !== '0 || icache_prefetch_enable_o !== 1'b1) begin
      @(negedge clk_i);
      wait_cycles++;
      if (wait_cycles >= ResetCycles) begin
        $display("Timeout waiting for reset to clear the wake-up bits and enable prefetch");
        $display("Simulation failed");
        $fatal(1, "Reset timeout");
      end
    end
    repeat (ResetCycles - wait_cycles) @(negedge clk_i);
    reset_i = 1'b0;
    foreach (table_q[i]) begin
      run_access(table_q[i]);
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

//--- test/cluster_peripheral_checker.sv
// Assertions on the register bus response and the wake-up lines.
// Bound into the cluster peripheral top level by the testbench.

`timescale 1ns/1ps

module cluster_peripheral_checker (
  input logic                                  clk_i,
  input logic                                  reset_i,
  input periph_reg_pkg::reg_req_t              reg_req_i,
  input periph_reg_pkg::reg_rsp_t              reg_rsp_i,
  input logic [cluster_periph_pkg::NrCores-1:0] cl_clint_i
);

  import periph_reg_pkg::*;

  logic clint_write;

  assign clint_write = reg_req_i.valid & reg_req_i.write &
                       (reg_req_i.addr == ClClintSetOffset ||
                        reg_req_i.addr == ClClintClearOffset);

  // Error only accompanies an access.
  error_needs_valid: assert property (@(posedge clk_i) reg_rsp_i.error |-> reg_req_i.valid)
    else $error("Bus error raised without a valid request");

  clint_zero_after_reset: assert property (@(posedge clk_i) $fell(reset_i) |-> cl_clint_i == '0)
    else $error("Wake-up bits not cleared by reset");

  // Wake-up lines move only one cycle after a set or clear write.
  clint_change_on_write: assert property (@(posedge clk_i) disable iff (reset_i)
    !$stable(cl_clint_i) |-> $past(clint_write))
    else $error("Wake-up bits changed without a set or clear write");

endmodule

//--- hw/cluster_peripheral.sv
// Top level of the cluster control peripheral. Connects the register file
// and the counter bank to the register bus and the cluster event ports.

`timescale 1ns/1ps

module cluster_peripheral (
  input  logic                                  clk_i,
  input  logic                                  reset_i,

  // Register bus.
  input  periph_reg_pkg::reg_req_t              reg_req_i,
  output periph_reg_pkg::reg_rsp_t              reg_rsp_o,

  input  logic [cluster_periph_pkg::HartIdWidth-1:0] hart_base_id_i,

  // Event sources.
  input  cluster_periph_pkg::core_events_t [cluster_periph_pkg::NrCores-1:0] core_events_i,
  input  cluster_periph_pkg::tcdm_events_t      tcdm_events_i,
  input  cluster_periph_pkg::dma_events_t       dma_events_i,
  input  cluster_periph_pkg::icache_events_t [cluster_periph_pkg::NrCores-1:0] icache_events_i,

  // Cluster controls.
  output logic [cluster_periph_pkg::NrCores-1:0] cl_clint_o,
  output logic                                  icache_prefetch_enable_o
);

  import cluster_periph_pkg::*;
  import periph_reg_pkg::*;

  perf_ctrl_t [NumPerfCounters-1:0] perf_ctrl;
  counter_t [NumPerfCounters-1:0]   perf_value;

  periph_reg_file periph_reg_file_inst (
    .clk_i                    (clk_i),
    .reset_i                  (reset_i),
    .reg_req_i                (reg_req_i),
    .reg_rsp_o                (reg_rsp_o),
    .hart_base_id_i           (hart_base_id_i),
    .perf_value_i             (perf_value),
    .perf_ctrl_o              (perf_ctrl),
    .cl_clint_o               (cl_clint_o),
    .icache_prefetch_enable_o (icache_prefetch_enable_o)
  );

  perf_counter_bank perf_counter_bank_inst (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .perf_ctrl_i     (perf_ctrl),
    .core_events_i   (core_events_i),
    .tcdm_events_i   (tcdm_events_i),
    .dma_events_i    (dma_events_i),
    .icache_events_i (icache_events_i),
    .perf_value_o    (perf_value)
  );

endmodule

//--- hw/perf_counter_bank.sv
// Bank of performance counters. Event inputs are registered once, then each
// counter adds the increment of its selected metric or takes a software load.

`timescale 1ns/1ps

module perf_counter_bank (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  periph_reg_pkg::perf_ctrl_t [cluster_periph_pkg::NumPerfCounters-1:0] perf_ctrl_i,
  input  cluster_periph_pkg::core_events_t [cluster_periph_pkg::NrCores-1:0] core_events_i,
  input  cluster_periph_pkg::tcdm_events_t      tcdm_events_i,
  input  cluster_periph_pkg::dma_events_t       dma_events_i,
  input  cluster_periph_pkg::icache_events_t [cluster_periph_pkg::NrCores-1:0] icache_events_i,
  output cluster_periph_pkg::counter_t [cluster_periph_pkg::NumPerfCounters-1:0] perf_value_o
);

  import cluster_periph_pkg::*;

  core_events_t [NrCores-1:0]   core_events_q;
  tcdm_events_t                 tcdm_events_q;
  dma_events_t                  dma_events_q;
  icache_events_t [NrCores-1:0] icache_events_q;

  counter_t [NumPerfCounters-1:0] counter_q;

  // Event pipeline stage to ease timing from the cores and the interconnect.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      core_events_q <= '0;
      tcdm_events_q <= '0;
      dma_events_q <= '0;
      icache_events_q <= '0;
    end else begin
      core_events_q <= core_events_i;
      tcdm_events_q <= tcdm_events_i;
      dma_events_q <= dma_events_i;
      icache_events_q <= icache_events_i;
    end
  end

  for (genvar i = 0; i < NumPerfCounters; i++) begin : gen_counter
    core_events_t   sel_core;
    icache_events_t sel_icache;
    counter_t       increment;
    counter_t       counter_d;

    // Per-core metrics follow the hart select of this counter.
    assign sel_core = core_events_q[perf_ctrl_i[i].hart_sel];
    assign sel_icache = icache_events_q[perf_ctrl_i[i].hart_sel];

    always_comb begin
      increment = '0;
      case (perf_ctrl_i[i].metric)
        Cycle: begin
          increment = counter_t'(1);
        end
        TcdmAccessed: begin
          increment = counter_t'(tcdm_events_q.accessed);
        end
        TcdmCongested: begin
          increment = counter_t'(tcdm_events_q.congested);
        end
        RetiredInstr: begin
          increment = counter_t'(sel_core.retired_instr);
        end
        RetiredLoad: begin
          increment = counter_t'(sel_core.retired_load);
        end
        DmaBusy: begin
          increment = counter_t'(dma_events_q.busy);
        end
        // Byte count adds its full value, not just one.
        DmaBytesWritten: begin
          increment = counter_t'(dma_events_q.bytes_written);
        end
        IcacheMiss: begin
          increment = counter_t'(sel_icache.miss);
        end
        IcacheHit: begin
          increment = counter_t'(sel_icache.hit);
        end
        default: begin
          increment = '0;
        end
      endcase
    end

    // A software load wins over any increment in the same cycle.
    assign counter_d = perf_ctrl_i[i].load_en ? counter_t'(perf_ctrl_i[i].load_data)
                                              : counter_q[i] + increment;

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        counter_q[i] <= '0;
      end else begin
        counter_q[i] <= counter_d;
      end
    end
  end

  assign perf_value_o = counter_q;

endmodule

//--- hw/periph_reg_file.sv
// Register file of the cluster peripheral. Decodes bus accesses, holds the
// control and wake-up registers and answers reads in the same cycle.

`timescale 1ns/1ps

module periph_reg_file (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  periph_reg_pkg::reg_req_t              reg_req_i,
  output periph_reg_pkg::reg_rsp_t              reg_rsp_o,
  input  logic [cluster_periph_pkg::HartIdWidth-1:0] hart_base_id_i,
  input  cluster_periph_pkg::counter_t [cluster_periph_pkg::NumPerfCounters-1:0] perf_value_i,
  output periph_reg_pkg::perf_ctrl_t [cluster_periph_pkg::NumPerfCounters-1:0] perf_ctrl_o,
  output logic [cluster_periph_pkg::NrCores-1:0] cl_clint_o,
  output logic                                  icache_prefetch_enable_o
);

  import cluster_periph_pkg::*;
  import periph_reg_pkg::*;

  logic                            write_access;
  logic                            addr_hit;
  logic                            read_only;
  logic [RegDataWidth-1:0]         rdata;

  logic                            prefetch_we;
  logic                            clint_set_we;
  logic                            clint_clear_we;
  logic [NumPerfCounters-1:0]      load_we;
  logic [NumPerfCounters-1:0]      metric_we;
  logic [NumPerfCounters-1:0]      hart_sel_we;

  logic                            prefetch_en_q;
  logic [NrCores-1:0]              cl_clint_q;
  perf_metric_e [NumPerfCounters-1:0] metric_q;
  hart_sel_t [NumPerfCounters-1:0] hart_sel_q;

  assign write_access = reg_req_i.valid & reg_req_i.write;

  // Address decode and read mux.
  always_comb begin
    addr_hit = 1'b0;
    read_only = 1'b0;
    rdata = '0;
    prefetch_we = 1'b0;
    clint_set_we = 1'b0;
    clint_clear_we = 1'b0;
    load_we = '0;
    metric_we = '0;
    hart_sel_we = '0;

    case (reg_req_i.addr)
      IcachePrefetchEnableOffset: begin
        addr_hit = 1'b1;
        rdata[0] = prefetch_en_q;
        prefetch_we = write_access;
      end
      // Set and clear are write-only and read back as zero.
      ClClintSetOffset: begin
        addr_hit = 1'b1;
        clint_set_we = write_access;
      end
      ClClintClearOffset: begin
        addr_hit = 1'b1;
        clint_clear_we = write_access;
      end
      ClClintOffset: begin
        addr_hit = 1'b1;
        read_only = 1'b1;
        rdata[NrCores-1:0] = cl_clint_q;
      end
      HartBaseIdOffset: begin
        addr_hit = 1'b1;
        read_only = 1'b1;
        rdata[HartIdWidth-1:0] = hart_base_id_i;
      end
      default: ;
    endcase

    for (int i = 0; i < NumPerfCounters; i++) begin
      if (reg_req_i.addr == PerfCounterLoOffset + 8'(PerfCounterStride * i)) begin
        addr_hit = 1'b1;
        rdata = perf_value_i[i][31:0];
        load_we[i] = write_access;
      end
      // Upper counter bits are visible but not writable.
      if (reg_req_i.addr == PerfCounterHiOffset + 8'(PerfCounterStride * i)) begin
        addr_hit = 1'b1;
        read_only = 1'b1;
        rdata[CounterWidth-33:0] = perf_value_i[i][CounterWidth-1:32];
      end
      if (reg_req_i.addr == PerfSelectOffset + 8'(PerfSelectStride * i)) begin
        addr_hit = 1'b1;
        rdata[3:0] = metric_q[i];
        metric_we[i] = write_access;
      end
      if (reg_req_i.addr == PerfHartSelectOffset + 8'(PerfSelectStride * i)) begin
        addr_hit = 1'b1;
        rdata[HartSelWidth-1:0] = hart_sel_q[i];
        hart_sel_we[i] = write_access;
      end
    end
  end

  assign reg_rsp_o.rdata = rdata;
  assign reg_rsp_o.error = reg_req_i.valid & (~addr_hit | (reg_req_i.write & read_only));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prefetch_en_q <= 1'b1;
      cl_clint_q <= '0;
      metric_q <= PerfMetricRstValues;
      hart_sel_q <= '0;
    end else begin
      if (prefetch_we) begin
        prefetch_en_q <= reg_req_i.wdata[0];
      end
      // Set and clear never coincide, they sit at different offsets.
      if (clint_set_we) begin
        cl_clint_q <= cl_clint_q | reg_req_i.wdata[NrCores-1:0];
      end
      if (clint_clear_we) begin
        cl_clint_q <= cl_clint_q & ~reg_req_i.wdata[NrCores-1:0];
      end
      for (int i = 0; i < NumPerfCounters; i++) begin
        if (metric_we[i]) begin
          metric_q[i] <= perf_metric_e'(reg_req_i.wdata[3:0]);
        end
        if (hart_sel_we[i]) begin
          hart_sel_q[i] <= reg_req_i.wdata[HartSelWidth-1:0];
        end
      end
    end
  end

  // Controls to the counter bank, load is a pulse in the write cycle.
  for (genvar i = 0; i < NumPerfCounters; i++) begin : gen_perf_ctrl
    assign perf_ctrl_o[i].metric = metric_q[i];
    assign perf_ctrl_o[i].hart_sel = hart_sel_q[i];
    assign perf_ctrl_o[i].load_en = load_we[i];
    assign perf_ctrl_o[i].load_data = reg_req_i.wdata;
  end

  assign cl_clint_o = cl_clint_q;
  assign icache_prefetch_enable_o = prefetch_en_q;

endmodule

//--- hw/periph_reg_pkg.sv
// Register bus request and response structs, the register map and the
// control struct that the register file hands to the counter bank.

package periph_reg_pkg;

  localparam int unsigned RegAddrWidth = 8;
  localparam int unsigned RegDataWidth = 32;

  // Bus request, one access per cycle while valid is high.
  typedef struct packed {
    logic                    valid;
    logic                    write;
    logic [RegAddrWidth-1:0] addr;
    logic [RegDataWidth-1:0] wdata;
  } reg_req_t;

  // Response comes back in the same cycle, so there is no ready.
  typedef struct packed {
    logic [RegDataWidth-1:0] rdata;
    logic                    error;
  } reg_rsp_t;

  // Fixed control registers.
  localparam logic [RegAddrWidth-1:0] IcachePrefetchEnableOffset = 8'h00;
  localparam logic [RegAddrWidth-1:0] ClClintSetOffset = 8'h04;
  localparam logic [RegAddrWidth-1:0] ClClintClearOffset = 8'h08;
  localparam logic [RegAddrWidth-1:0] ClClintOffset = 8'h0C;
  localparam logic [RegAddrWidth-1:0] HartBaseIdOffset = 8'h10;

  // Counter registers, base of counter 0 plus index times stride.
  localparam logic [RegAddrWidth-1:0] PerfCounterLoOffset = 8'h20;
  localparam logic [RegAddrWidth-1:0] PerfCounterHiOffset = 8'h24;
  localparam int unsigned PerfCounterStride = 8;

  localparam logic [RegAddrWidth-1:0] PerfSelectOffset = 8'h40;
  localparam logic [RegAddrWidth-1:0] PerfHartSelectOffset = 8'h50;
  localparam int unsigned PerfSelectStride = 4;

  // Per-counter controls from the register file.
  // The load strobe lasts the one cycle of the write to the low word.
  typedef struct packed {
    cluster_periph_pkg::perf_metric_e metric;
    cluster_periph_pkg::hart_sel_t    hart_sel;
    logic                             load_en;
    logic [RegDataWidth-1:0]          load_data;
  } perf_ctrl_t;

endpackage

//--- hw/cluster_periph_pkg.sv
// Cluster-wide sizes, event input structs and the performance metric codes.
// Shared by the register file, the counter bank and the top level.

package cluster_periph_pkg;

  // Cluster dimensions.
  localparam int unsigned NrCores = 4;
  localparam int unsigned NumPerfCounters = 4;
  localparam int unsigned CounterWidth = 48;
  localparam int unsigned HartIdWidth = 10;
  localparam int unsigned HartSelWidth = $clog2(NrCores);
  localparam int unsigned DmaBytesWidth = 8;

  typedef logic [CounterWidth-1:0] counter_t;
  typedef logic [HartSelWidth-1:0] hart_sel_t;

  // Per-core events, one strobe per retired instruction or load.
  typedef struct packed {
    logic retired_instr;
    logic retired_load;
  } core_events_t;

  // Interconnect events.
  typedef struct packed {
    logic accessed;
    logic congested;
  } tcdm_events_t;

  // DMA events, bytes_written is a count for the current cycle.
  typedef struct packed {
    logic                     busy;
    logic [DmaBytesWidth-1:0] bytes_written;
  } dma_events_t;

  // Per-core instruction cache events.
  typedef struct packed {
    logic miss;
    logic hit;
  } icache_events_t;

  // Metric codes as seen by software in the select registers.
  typedef enum logic [3:0] {
    Cycle           = 4'd0,
    TcdmAccessed    = 4'd1,
    TcdmCongested   = 4'd2,
    RetiredInstr    = 4'd3,
    RetiredLoad     = 4'd4,
    DmaBusy         = 4'd5,
    DmaBytesWritten = 4'd6,
    IcacheMiss      = 4'd7,
    IcacheHit       = 4'd8
  } perf_metric_e;

  // Metric tracked by each counter right after reset, counter 0 in the low slot.
  localparam perf_metric_e [NumPerfCounters-1:0] PerfMetricRstValues = {
    IcacheMiss,
    TcdmAccessed,
    RetiredInstr,
    Cycle
  };

endpackage
